/* vlog.f */
hdl/icache_pkg.sv
hdl/simple_dual_port_ram.sv
hdl/icache_way.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_assertions.sv
testbench/tb_icache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

    import icache_pkg::*;

    // about 120 accesses at up to 8 cycles each, the 128-cycle sweep, and margin
    localparam int MAX_CYCLES = 4000;
    localparam int RAND_NUM   = 100;

    localparam logic [1:0] KIND_ANY  = 2'd0;
    localparam logic [1:0] KIND_HIT  = 2'd1;
    localparam logic [1:0] KIND_MISS = 2'd2;
    localparam logic [1:0] KIND_UC   = 2'd3;

    typedef struct packed {
        addr_t       pc;
        inst_t       inst;
        logic [1:0]  kind;
        logic [31:0] cycle;
    } exp_entry_t;

    logic        clk;
    logic        reset;
    logic        req_valid_i;
    fetch_req_t  req_i;
    logic        flush_i;
    logic        cacop_en_i;
    cacop_mode_t cacop_mode_i;
    addr_t       cacop_addr_i;
    logic        stall_o;
    logic        resp_valid_o;
    fetch_resp_t resp_o;
    logic        rd_req_o;
    addr_t       rd_addr_o;
    logic        ret_valid_i = 1'b0;
    line_t       ret_data_i  = '0;
    logic        uc_ren_o;
    addr_t       uc_addr_o;
    logic        uc_rvalid_i = 1'b0;
    inst_t       uc_rdata_i  = '0;

    integer     seed        = 75899;
    int         errors      = 0;
    int         cycle       = 0;
    int         refill_wait = 0;
    logic       stall_q     = 1'b1;
    logic       rd_req_q    = 1'b0;
    logic       uc_ren_q    = 1'b0;
    logic       rd_seen     = 1'b0;
    logic       uc_seen     = 1'b0;
    string      test_name   = "reset";
    exp_entry_t exp_q [$];
    addr_t      rand_pc [RAND_NUM];
    logic       rand_uc [RAND_NUM];

    icache_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic inst_t cached_word(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic line_t memory_line(input addr_t a);
        line_t l;
        for (int i = 0; i < BANK_NUM; i++) begin
            l[32*i +: 32] = cached_word({a[31:5], 3'(i), 2'b00});
        end
        return l;
    endfunction

    function automatic void compare_word(input string what, input logic [31:0] expected,
                                         input logic [31:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endfunction

    function automatic void expect_true(input logic cond, input string msg);
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s: %s", test_name, msg);
        end
    endfunction

    // refill memory, answers after a random delay
    always @(negedge clk) begin
        if (ret_valid_i) begin
            ret_valid_i = 1'b0;
        end else if (refill_wait > 0) begin
            refill_wait = refill_wait - 1;
            if (refill_wait == 0) begin
                ret_valid_i = 1'b1;
                ret_data_i  = memory_line(rd_addr_o);
            end
        end else if (rd_req_q) begin
            refill_wait = 1 + {$random(seed)} % 6;
        end
    end

    // uncached memory
    always @(negedge clk) begin
        if (uc_rvalid_i) begin
            uc_rvalid_i = 1'b0;
        end else if (uc_ren_q) begin
            uc_rvalid_i = 1'b1;
            uc_rdata_i  = ~uc_addr_o;
        end
    end

    always @(posedge clk) begin : monitor
        exp_entry_t e;
        cycle    <= cycle + 1;
        stall_q  <= stall_o;
        rd_req_q <= rd_req_o;
        uc_ren_q <= uc_ren_o;
        if (!reset) begin
            if (rd_req_o) begin
                rd_seen = 1'b1;
                if (exp_q.size() > 0) begin
                    compare_word("refill address", {exp_q[0].pc[31:5], 5'd0}, rd_addr_o);
                end
            end
            if (uc_ren_o) begin
                uc_seen = 1'b1;
            end
            if (resp_valid_o && exp_q.size() == 0) begin
                expect_true(1'b0, "response arrived with no fetch outstanding");
            end else if (resp_valid_o) begin
                e = exp_q.pop_front();
                compare_word("pc", e.pc, resp_o.pc);
                compare_word("inst", e.inst, resp_o.inst);
                if (e.kind == KIND_HIT) begin
                    compare_word("hit cycle", e.cycle, 32'(cycle));
                    expect_true(!rd_seen, "a refill was requested for a fetch that should hit");
                end else if (e.kind == KIND_MISS) begin
                    expect_true(rd_seen && !uc_seen, "a fetch that should miss did no refill");
                end else if (e.kind == KIND_UC) begin
                    expect_true(uc_seen && !rd_seen, "uncached fetch did not use the uc port");
                end
                rd_seen = 1'b0;
                uc_seen = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // entered and left on a falling edge, request dropped once accepted
    task automatic issue(input addr_t pc, input logic uc);
        req_valid_i    = 1'b1;
        req_i.pc       = pc;
        req_i.uncached = uc;
        @(negedge clk);
        while (stall_q) @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic fetch(input addr_t pc, input logic uc, input logic [1:0] kind);
        exp_entry_t e;
        issue(pc, uc);
        e.pc    = pc;
        e.inst  = uc ? ~pc : cached_word({pc[31:2], 2'b00});
        e.kind  = kind;
        e.cycle = 32'(cycle);
        exp_q.push_back(e);
    endtask

    task automatic flushed_fetch(input addr_t pc);
        issue(pc, 1'b0);
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    // an honored command holds stall high for two cycles
    task automatic cache_op(input cacop_mode_t mode, input addr_t a);
        logic honored;
        while (stall_o) @(negedge clk);
        honored      = (mode != 2'd3);
        cacop_en_i   = 1'b1;
        cacop_mode_i = mode;
        cacop_addr_i = a;
        @(negedge clk);
        cacop_en_i = 1'b0;
        compare_word("stall cycle 1", {31'd0, honored}, {31'd0, stall_o});
        @(negedge clk);
        compare_word("stall cycle 2", {31'd0, honored}, {31'd0, stall_o});
        @(negedge clk);
        compare_word("stall cycle 3", 32'd0, {31'd0, stall_o});
    endtask

    task automatic drain();
        req_valid_i = 1'b0;
        while (exp_q.size() != 0 || stall_o) @(negedge clk);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        reset        = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        flush_i      = 1'b0;
        cacop_en_i   = 1'b0;
        cacop_mode_i = '0;
        cacop_addr_i = '0;
        // 4 tags x 4 sets, so both ways fill and get replaced
        for (int n = 0; n < RAND_NUM; n++) begin
            r          = $random(seed);
            rand_pc[n] = {18'd0, r[1:0], 5'd0, r[3:2], r[6:4], 2'b00};
            rand_uc[n] = (r[10:8] == 3'd0);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (stall_o) @(negedge clk);
        expect_true(!rd_req_o && !uc_ren_o && !resp_valid_o, "outputs busy after the sweep");

        test_name = "first miss";
        fetch(32'h0000_1234, 1'b0, KIND_MISS);
        drain();

        test_name = "hit stream";
        fetch(32'h0000_1220, 1'b0, KIND_HIT);
        fetch(32'h0000_1224, 1'b0, KIND_HIT);
        fetch(32'h0000_1238, 1'b0, KIND_HIT);
        fetch(32'h0000_123c, 1'b0, KIND_HIT);
        drain();

        // A, B and C share set 5
        test_name = "replacement";
        fetch(32'h0001_00a0, 1'b0, KIND_MISS);
        fetch(32'h0002_00a4, 1'b0, KIND_MISS);
        fetch(32'h0001_00a8, 1'b0, KIND_HIT);
        fetch(32'h0003_00ac, 1'b0, KIND_MISS);
        fetch(32'h0001_00b0, 1'b0, KIND_HIT);
        fetch(32'h0002_00b4, 1'b0, KIND_MISS);
        drain();

        test_name = "cache op";
        for (int m = 0; m < 3; m++) begin
            cache_op(cacop_mode_t'(m), 32'h0000_1234);
            fetch(32'h0000_1234, 1'b0, KIND_MISS);
        end
        cache_op(2'd3, 32'h0000_1234);
        fetch(32'h0000_1234, 1'b0, KIND_HIT);
        drain();

        test_name = "uncached";
        fetch(32'h8000_0010, 1'b1, KIND_UC);
        fetch(32'h8000_0014, 1'b1, KIND_UC);
        drain();

        test_name = "flush";
        flushed_fetch(32'h0000_1238);
        flushed_fetch(32'h0005_0000);
        fetch(32'h0005_0004, 1'b0, KIND_MISS);
        fetch(32'h0000_1238, 1'b0, KIND_HIT);
        drain();

        test_name = "random";
        for (int n = 0; n < RAND_NUM; n++) begin
            fetch(rand_pc[n], rand_uc[n], KIND_ANY);
        end
        drain();

        $display("errors: %0d, assertion failures: %0d", errors, u_dut.u_assert.fail_count);
        if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* testbench/icache_assertions.sv */
`timescale 1ns/100ps

module icache_assertions (
    input logic clk,
    input logic reset,
    input logic stall_i,
    input logic resp_valid_i,
    input logic rd_req_i,
    input logic ret_valid_i,
    input logic uc_ren_i,
    input logic uc_rvalid_i
);

    int fail_count = 0;

    // refill request held until the line returns
    refill_held: assert property (@(posedge clk) disable iff (reset)
        rd_req_i && !ret_valid_i |=> rd_req_i)
        else begin
            fail_count++;
            $error("refill request dropped before the line returned");
        end

    refill_released: assert property (@(posedge clk) disable iff (reset)
        rd_req_i && ret_valid_i |=> !rd_req_i)
        else begin
            fail_count++;
            $error("refill request still high the cycle after the line returned");
        end

    uncached_held: assert property (@(posedge clk) disable iff (reset)
        uc_ren_i && !uc_rvalid_i |=> uc_ren_i)
        else begin
            fail_count++;
            $error("uncached read dropped before its data returned");
        end

    // core released the cycle after memory answers
    stall_released: assert property (@(posedge clk) disable iff (reset)
        (rd_req_i && ret_valid_i) || (uc_ren_i && uc_rvalid_i) |=> !stall_i)
        else begin
            fail_count++;
            $error("stall still high the cycle after memory answered");
        end

    // nothing to answer with while memory is still busy
    quiet_while_pending: assert property (@(posedge clk) disable iff (reset)
        (rd_req_i && !ret_valid_i) || (uc_ren_i && !uc_rvalid_i) |-> !resp_valid_i)
        else begin
            fail_count++;
            $error("response issued while a memory read was pending");
        end

endmodule

bind icache_top icache_assertions u_assert (
    .clk          (clk),
    .reset        (reset),
    .stall_i      (stall_o),
    .resp_valid_i (resp_valid_o),
    .rd_req_i     (rd_req_o),
    .ret_valid_i  (ret_valid_i),
    .uc_ren_i     (uc_ren_o),
    .uc_rvalid_i  (uc_rvalid_i)
);

/* hdl/icache_top.sv */
`timescale 1ns/100ps

module icache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid_i,
    input  icache_pkg::fetch_req_t  req_i,
    input  logic                    flush_i,
    input  logic                    cacop_en_i,
    input  icache_pkg::cacop_mode_t cacop_mode_i,
    input  icache_pkg::addr_t       cacop_addr_i,
    output logic                    stall_o,
    output logic                    resp_valid_o,
    output icache_pkg::fetch_resp_t resp_o,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o,
    input  logic                    ret_valid_i,
    input  icache_pkg::line_t       ret_data_i,
    output logic                    uc_ren_o,
    output icache_pkg::addr_t       uc_addr_o,
    input  logic                    uc_rvalid_i,
    input  icache_pkg::inst_t       uc_rdata_i
);

    import icache_pkg::*;

    index_t    rd_index;
    tag_t      cmp_tag;
    word_sel_t word_sel;
    logic [1:0] way_hit;
    inst_t     way0_word;
    inst_t     way1_word;
    logic [1:0] way_wr_en;
    logic      line_wr_en;
    index_t    wr_index;
    tagv_t     wr_tagv;
    line_t     wr_line;
    logic [1:0] way_busy;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .flush_i      (flush_i),
        .cacop_en_i   (cacop_en_i),
        .cacop_mode_i (cacop_mode_i),
        .cacop_addr_i (cacop_addr_i),
        .stall_o      (stall_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .uc_ren_o     (uc_ren_o),
        .uc_addr_o    (uc_addr_o),
        .uc_rvalid_i  (uc_rvalid_i),
        .uc_rdata_i   (uc_rdata_i),
        .rd_index_o   (rd_index),
        .cmp_tag_o    (cmp_tag),
        .word_sel_o   (word_sel),
        .way_hit_i    (way_hit),
        .way0_word_i  (way0_word),
        .way1_word_i  (way1_word),
        .way_wr_en_o  (way_wr_en),
        .line_wr_en_o (line_wr_en),
        .wr_index_o   (wr_index),
        .wr_tagv_o    (wr_tagv),
        .wr_line_o    (wr_line),
        .sweep_busy_i (|way_busy)
    );

    icache_way u_way0 (
        .clk          (clk),
        .reset        (reset),
        .rd_index_i   (rd_index),
        .cmp_tag_i    (cmp_tag),
        .word_sel_i   (word_sel),
        .wr_en_i      (way_wr_en[0]),
        .wr_line_en_i (line_wr_en),
        .wr_index_i   (wr_index),
        .wr_tagv_i    (wr_tagv),
        .wr_line_i    (wr_line),
        .hit_o        (way_hit[0]),
        .word_o       (way0_word),
        .sweep_busy_o (way_busy[0])
    );

    icache_way u_way1 (
        .clk          (clk),
        .reset        (reset),
        .rd_index_i   (rd_index),
        .cmp_tag_i    (cmp_tag),
        .word_sel_i   (word_sel),
        .wr_en_i      (way_wr_en[1]),
        .wr_line_en_i (line_wr_en),
        .wr_index_i   (wr_index),
        .wr_tagv_i    (wr_tagv),
        .wr_line_i    (wr_line),
        .hit_o        (way_hit[1]),
        .word_o       (way1_word),
        .sweep_busy_o (way_busy[1])
    );

endmodule

/* hdl/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid_i,
    input  icache_pkg::fetch_req_t  req_i,
    input  logic                    flush_i,
    input  logic                    cacop_en_i,
    input  icache_pkg::cacop_mode_t cacop_mode_i,
    input  icache_pkg::addr_t       cacop_addr_i,
    output logic                    stall_o,
    output logic                    resp_valid_o,
    output icache_pkg::fetch_resp_t resp_o,
    output logic                    rd_req_o,
    output icache_pkg::addr_t       rd_addr_o,
    input  logic                    ret_valid_i,
    input  icache_pkg::line_t       ret_data_i,
    output logic                    uc_ren_o,
    output icache_pkg::addr_t       uc_addr_o,
    input  logic                    uc_rvalid_i,
    input  icache_pkg::inst_t       uc_rdata_i,
    output icache_pkg::index_t      rd_index_o,
    output icache_pkg::tag_t        cmp_tag_o,
    output icache_pkg::word_sel_t   word_sel_o,
    input  logic [1:0]              way_hit_i,
    input  icache_pkg::inst_t       way0_word_i,
    input  icache_pkg::inst_t       way1_word_i,
    output logic [1:0]              way_wr_en_o,
    output logic                    line_wr_en_o,
    output icache_pkg::index_t      wr_index_o,
    output icache_pkg::tagv_t       wr_tagv_o,
    output icache_pkg::line_t       wr_line_o,
    input  logic                    sweep_busy_i
);

    import icache_pkg::*;

    icache_state_t state;
    fetch_req_t    req_q;
    logic          req_vld;
    logic          cacop_phase;
    index_t        cacop_idx;
    logic [SET_NUM-1:0] lru;

    logic   lookup_live;
    logic   hit_any;
    logic   hit_done;
    logic   miss_start;
    logic   uc_start;
    logic   fill_done;
    logic   uc_done;
    logic   accept;
    logic   cacop_go;
    logic   victim;
    index_t req_idx;
    inst_t  fill_word;

    assign req_idx    = req_q.pc[11:5];
    assign rd_index_o = req_i.pc[11:5];
    assign cmp_tag_o  = req_q.pc[31:12];
    assign word_sel_o = req_q.pc[4:2];

    // a flush in the lookup cycle drops the request before any refill
    assign lookup_live = (state == ST_IDLE) && req_vld && !flush_i;
    assign hit_any     = |way_hit_i;
    assign hit_done    = lookup_live && !req_q.uncached && hit_any;
    assign miss_start  = lookup_live && !req_q.uncached && !hit_any;
    assign uc_start    = lookup_live && req_q.uncached;
    assign fill_done   = (state == ST_MISS) && ret_valid_i;
    assign uc_done     = (state == ST_UNCACHED) && uc_rvalid_i;

    assign stall_o  = sweep_busy_i || (state != ST_IDLE) || miss_start || uc_start;
    assign cacop_go = cacop_en_i && !stall_o && (cacop_mode_i != 2'd3);
    assign accept   = req_valid_i && !stall_o && !flush_i && !cacop_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            cacop_phase <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cacop_go) begin
                        state <= ST_CACOP;
                    end else if (miss_start) begin
                        state <= ST_MISS;
                    end else if (uc_start) begin
                        state <= ST_UNCACHED;
                    end
                end
                ST_MISS: begin
                    if (ret_valid_i) begin
                        state <= ST_IDLE;
                    end
                end
                ST_UNCACHED: begin
                    if (uc_rvalid_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    // tag write, then one settling cycle
                    cacop_phase <= ~cacop_phase;
                    if (cacop_phase) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_vld <= 1'b0;
        end else if (flush_i) begin
            req_vld <= 1'b0;
        end else if (accept) begin
            req_vld <= 1'b1;
        end else if (!stall_o || fill_done || uc_done) begin
            req_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (cacop_go) begin
            cacop_idx <= cacop_addr_i[11:5];
        end
    end

    // lru bit names the next victim
    assign victim = lru[req_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (hit_done) begin
            lru[req_idx] <= way_hit_i[0];
        end else if (fill_done) begin
            lru[req_idx] <= ~victim;
        end
    end

    assign fill_word = ret_data_i[32*word_sel_o +: 32];

    always_comb begin
        resp_o.pc = req_q.pc;
        if (state == ST_UNCACHED) begin
            resp_o.inst = uc_rdata_i;
        end else if (state == ST_MISS) begin
            resp_o.inst = fill_word;
        end else begin
            resp_o.inst = way_hit_i[0] ? way0_word_i : way1_word_i;
        end
    end

    assign resp_valid_o = hit_done || ((fill_done || uc_done) && req_vld && !flush_i);

    assign rd_req_o  = miss_start || (state == ST_MISS);
    assign rd_addr_o = {req_q.pc[31:OFFSET_W], OFFSET_W'(0)};
    assign uc_ren_o  = uc_start || (state == ST_UNCACHED);
    assign uc_addr_o = req_q.pc;

    always_comb begin
        way_wr_en_o  = 2'b00;
        line_wr_en_o = 1'b0;
        wr_index_o   = req_idx;
        wr_tagv_o    = {1'b1, req_q.pc[31:12]};
        if ((state == ST_CACOP) && !cacop_phase) begin
            // invalidate both ways of the set
            way_wr_en_o = 2'b11;
            wr_index_o  = cacop_idx;
            wr_tagv_o   = '0;
        end else if (fill_done) begin
            way_wr_en_o[victim] = 1'b1;
            line_wr_en_o        = 1'b1;
        end
    end

    assign wr_line_o = ret_data_i;

endmodule

/* hdl/icache_way.sv */
`timescale 1ns/100ps

module icache_way (
    input  logic                  clk,
    input  logic                  reset,
    input  icache_pkg::index_t    rd_index_i,
    input  icache_pkg::tag_t      cmp_tag_i,
    input  icache_pkg::word_sel_t word_sel_i,
    input  logic                  wr_en_i,
    input  logic                  wr_line_en_i,
    input  icache_pkg::index_t    wr_index_i,
    input  icache_pkg::tagv_t     wr_tagv_i,
    input  icache_pkg::line_t     wr_line_i,
    output logic                  hit_o,
    output icache_pkg::inst_t     word_o,
    output logic                  sweep_busy_o
);

    import icache_pkg::*;

    index_t sweep_idx;
    logic   sweep_busy;
    logic   tag_we;
    index_t tag_waddr;
    tagv_t  tag_wdata;
    tagv_t  tagv_q;
    logic   bank_we;
    inst_t  bank_word [BANK_NUM];

    // clear every valid bit once after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == index_t'(SET_NUM - 1)) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    assign tag_we    = sweep_busy | wr_en_i;
    assign tag_waddr = sweep_busy ? sweep_idx : wr_index_i;
    assign tag_wdata = sweep_busy ? '0 : wr_tagv_i;
    assign bank_we   = wr_en_i & wr_line_en_i & ~sweep_busy;

    simple_dual_port_ram #(.WIDTH(TAGV_W), .DEPTH(SET_NUM)) u_tagv (
        .clk       (clk),
        .wr_en_i   (tag_we),
        .wr_addr_i (tag_waddr),
        .wr_data_i (tag_wdata),
        .rd_addr_i (rd_index_i),
        .rd_data_o (tagv_q)
    );

    for (genvar i = 0; i < BANK_NUM; i++) begin : g_bank
        simple_dual_port_ram #(.WIDTH(32), .DEPTH(SET_NUM)) u_bank (
            .clk       (clk),
            .wr_en_i   (bank_we),
            .wr_addr_i (wr_index_i),
            .wr_data_i (wr_line_i[32*i +: 32]),
            .rd_addr_i (rd_index_i),
            .rd_data_o (bank_word[i])
        );
    end

    assign hit_o        = tagv_q[TAGV_W-1] && (tagv_q[TAG_W-1:0] == cmp_tag_i) && !sweep_busy;
    assign word_o       = bank_word[word_sel_i];
    assign sweep_busy_o = sweep_busy;

endmodule

/* hdl/simple_dual_port_ram.sv */
`timescale 1ns/100ps

module simple_dual_port_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128
) (
    input  logic               clk,
    input  logic               wr_en_i,
    input  icache_pkg::index_t wr_addr_i,
    input  logic [WIDTH-1:0]   wr_data_i,
    input  icache_pkg::index_t rd_addr_i,
    output logic [WIDTH-1:0]   rd_data_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* hdl/icache_pkg.sv */
package icache_pkg;

    // address split: tag 31:12, index 11:5, offset 4:0
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;
    localparam int BANK_NUM = 8;
    localparam int SET_NUM  = 128;
    localparam int TAGV_W   = 21;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // bank i sits at bits 32*i up
    typedef logic [BANK_NUM*32-1:0] line_t;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-3:0] word_sel_t;

    // valid bit on top
    typedef logic [TAGV_W-1:0] tagv_t;

    typedef logic [1:0] cacop_mode_t;

    typedef struct packed {
        addr_t pc;
        logic  uncached;
    } fetch_req_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_resp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS,
        ST_UNCACHED,
        ST_CACOP
    } icache_state_t;

endpackage
